// ==== files.f ====
+incdir+include
source/alu_pkg.sv
source/decoder_pkg.sv
source/first_nibble_decode.sv
source/block_0x_decode.sv
source/operand_collector.sv
source/decoder_fsm.sv
source/saturn_decoder.sv
test/tb_saturn_decoder.sv

// ==== source/alu_pkg.sv ====
// ALU operation codes for the execution unit
// the decoder attaches one of these to every decoded instruction record
`default_nettype none

package alu_pkg;

  // 5 bits wide so that the arithmetic ops of the full core fit later
  typedef enum logic [4:0] {
    NONE     = 5'd0,
    // register to register copy, also used for immediate loads
    COPY     = 5'd1,
    ZERO     = 5'd2,
    EXCH     = 5'd3,
    INC      = 5'd4,
    DEC      = 5'd5,
    // pc relative jumps, named after the offset size in nibbles
    JMP_REL2 = 5'd6,
    JMP_REL3 = 5'd7
  } alu_op_t;

endpackage

`default_nettype wire

// ==== source/block_0x_decode.sv ====
// decode of the second nibble in the 0x group
// returns, mode switches, return stack and status register moves,
// and the P register increment and decrement
`timescale 1ns/10ps
`default_nettype none

module block_0x_decode (
  input  logic [decoder_pkg::NIBBLE_W-1:0]  i_nibble,
  output decoder_pkg::ins_flags_t           o_flags,
  output alu_pkg::alu_op_t                  o_alu_op,
  output logic                              o_error
);

  always_comb begin
    o_flags  = '0;
    o_alu_op = alu_pkg::NONE;
    o_error  = 1'b0;

    case (i_nibble)
      // RTNSXM RTN RTNSC RTNCC, and RTI on F
      4'h0, 4'h1, 4'h2, 4'h3, 4'hF: begin
        o_flags.rtn       = 1'b1;
        o_flags.pop       = 1'b1;
        o_flags.set_xm    = (i_nibble == 4'h0);
        o_flags.set_carry = i_nibble[1] && !i_nibble[3];
        o_flags.carry_val = i_nibble[1] && !i_nibble[0];
        o_flags.en_intr   = i_nibble[3];
      end
      // SETHEX, SETDEC
      4'h4, 4'h5: begin
        o_flags.set_mode = 1'b1;
        o_flags.mode_dec = i_nibble[0];
      end
      // RSTK=C pushes, C=RSTK pops
      4'h6, 4'h7: begin
        o_alu_op          = alu_pkg::COPY;
        o_flags.alu_valid = 1'b1;
        o_flags.push      = !i_nibble[0];
        o_flags.pop       = i_nibble[0];
      end
      // CLRST
      4'h8: begin
        o_alu_op          = alu_pkg::ZERO;
        o_flags.alu_valid = 1'b1;
      end
      // C=ST, ST=C
      4'h9, 4'hA: begin
        o_alu_op          = alu_pkg::COPY;
        o_flags.alu_valid = 1'b1;
      end
      4'hB: begin
        o_alu_op          = alu_pkg::EXCH;
        o_flags.alu_valid = 1'b1;
      end
      // P=P+1, P=P-1
      4'hC, 4'hD: begin
        o_alu_op          = i_nibble[0] ? alu_pkg::DEC : alu_pkg::INC;
        o_flags.alu_valid = 1'b1;
      end
      default: begin
        o_error = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/decoder_fsm.sv ====
// sequencer of the instruction decoder
// walks each instruction nibble by nibble, picks the result of the
// matching combinational decoder and registers the record and its address
`timescale 1ns/10ps
`default_nettype none

module decoder_fsm #(
  parameter int ADDR_W = 20
) (
  input  logic                                i_clk,
  input  logic                                i_reset,
  input  logic                                i_nibble_valid,
  input  logic [decoder_pkg::NIBBLE_W-1:0]    i_nibble,
  input  logic [ADDR_W-1:0]                   i_pc,
  input  decoder_pkg::decode_state_t          i_route,
  input  decoder_pkg::ins_flags_t             i_first_flags,
  input  alu_pkg::alu_op_t                    i_first_alu_op,
  input  decoder_pkg::operand_len_t           i_first_len,
  input  logic                                i_first_error,
  input  decoder_pkg::ins_flags_t             i_0x_flags,
  input  alu_pkg::alu_op_t                    i_0x_alu_op,
  input  logic                                i_0x_error,
  input  logic                                i_collect_last,
  output logic                                o_collect_start,
  output decoder_pkg::operand_len_t           o_collect_len,
  output logic                                o_collect,
  output logic                                o_ins_decoded,
  output logic                                o_dec_error,
  output decoder_pkg::decoded_ins_t           o_ins,
  output logic [ADDR_W-1:0]                   o_ins_addr
);

  decoder_pkg::decode_state_t state;

  logic first_nibble;
  logic len_nibble;

  assign first_nibble = i_nibble_valid && (state == decoder_pkg::IDLE);
  assign len_nibble   = i_nibble_valid && (state == decoder_pkg::BLOCK_3X_LEN);

  // every first nibble restarts the collector, so instructions without
  // an operand report a length of 0; 3n restarts it again with n+1
  assign o_collect_start = first_nibble || len_nibble;
  assign o_collect_len   = len_nibble ? ({1'b0, i_nibble} + 5'd1) : i_first_len;
  assign o_collect       = i_nibble_valid && (state == decoder_pkg::COLLECT);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state         <= decoder_pkg::IDLE;
      o_ins_decoded <= 1'b0;
      o_dec_error   <= 1'b0;
    end else begin
      o_ins_decoded <= 1'b0;
      o_dec_error   <= 1'b0;
      if (i_nibble_valid) begin
        case (state)
          decoder_pkg::IDLE: begin
            if (i_first_error) begin
              o_dec_error <= 1'b1;
            end else begin
              state <= i_route;
            end
          end
          decoder_pkg::BLOCK_0X: begin
            o_ins_decoded <= !i_0x_error;
            o_dec_error   <= i_0x_error;
            state         <= decoder_pkg::IDLE;
          end
          decoder_pkg::BLOCK_2X: begin
            o_ins_decoded <= 1'b1;
            state         <= decoder_pkg::IDLE;
          end
          decoder_pkg::BLOCK_3X_LEN: begin
            state <= decoder_pkg::COLLECT;
          end
          decoder_pkg::COLLECT: begin
            if (i_collect_last) begin
              o_ins_decoded <= 1'b1;
              state         <= decoder_pkg::IDLE;
            end
          end
          default: begin
            state <= decoder_pkg::IDLE;
          end
        endcase
      end
    end
  end

  // record and start address
  always_ff @(posedge i_clk) begin
    if (i_nibble_valid) begin
      case (state)
        decoder_pkg::IDLE: begin
          o_ins_addr      <= i_pc;
          o_ins.flags     <= i_first_flags;
          o_ins.alu_op    <= i_first_alu_op;
          o_ins.imm_value <= '0;
        end
        decoder_pkg::BLOCK_0X: begin
          o_ins.flags  <= i_0x_flags;
          o_ins.alu_op <= i_0x_alu_op;
        end
        // P=n
        decoder_pkg::BLOCK_2X: begin
          o_ins.flags.alu_valid <= 1'b1;
          o_ins.alu_op          <= alu_pkg::COPY;
          o_ins.imm_value       <= i_nibble;
        end
        // load constant, the value streams into the collector
        decoder_pkg::BLOCK_3X_LEN: begin
          o_ins.flags.no_stall <= 1'b1;
          o_ins.alu_op         <= alu_pkg::COPY;
        end
        decoder_pkg::COLLECT: begin
          o_ins.flags.alu_valid <= 1'b1;
          o_ins.imm_value       <= i_nibble;
        end
        default: begin
        end
      endcase
    end
  end

  strobes_exclusive_a: assert property (@(posedge i_clk) disable iff (i_reset)
    !(o_ins_decoded && o_dec_error));

  // an operand is only left once the collector flags its last nibble
  collect_exit_a: assert property (@(posedge i_clk) disable iff (i_reset)
    (state == decoder_pkg::COLLECT) && !(i_nibble_valid && i_collect_last)
    |=> (state == decoder_pkg::COLLECT));

endmodule

`default_nettype wire

// ==== source/decoder_pkg.sv ====
// types and constants shared by the nibble-serial instruction decoder
// holds the sequencer states, the decoded record layout and operand sizes
`default_nettype none

package decoder_pkg;

  localparam int NIBBLE_W = 4;

  // a 4-bit length field in 3n encodes up to 16 nibbles
  localparam int MAX_OPERAND_NIBBLES = 16;

  // offset lengths of the relative jumps
  localparam logic [4:0] JMP_REL2_LEN = 5'd2;
  localparam logic [4:0] JMP_REL3_LEN = 5'd3;

  // nibble k of the buffer holds the k-th collected nibble
  typedef logic [MAX_OPERAND_NIBBLES*NIBBLE_W-1:0] operand_t;

  // 0 to 16 collected nibbles
  typedef logic [4:0] operand_len_t;

  typedef enum logic [2:0] {
    IDLE,
    BLOCK_0X,
    BLOCK_2X,
    BLOCK_3X_LEN,
    COLLECT
  } decode_state_t;

  typedef struct packed {
    // return and stack handling
    logic rtn;
    logic pop;
    logic push;
    logic set_xm;
    logic set_carry;
    logic carry_val;
    logic en_intr;
    // hex or decimal arithmetic mode
    logic set_mode;
    logic mode_dec;
    // conditional jumps
    logic test_carry;
    logic alu_valid;
    // executor keeps the stream running
    logic no_stall;
  } ins_flags_t;

  typedef struct packed {
    ins_flags_t             flags;
    alu_pkg::alu_op_t       alu_op;
    logic [NIBBLE_W-1:0]    imm_value;
  } decoded_ins_t;

endpackage

`default_nettype wire

// ==== source/first_nibble_decode.sv ====
// decode of the opening nibble of an instruction
// selects the follow-up state and sets up the relative jumps
`timescale 1ns/10ps
`default_nettype none

module first_nibble_decode (
  input  logic [decoder_pkg::NIBBLE_W-1:0]  i_nibble,
  output decoder_pkg::decode_state_t        o_route,
  output decoder_pkg::ins_flags_t           o_flags,
  output alu_pkg::alu_op_t                  o_alu_op,
  output decoder_pkg::operand_len_t         o_len,
  output logic                              o_error
);

  always_comb begin
    o_route  = decoder_pkg::IDLE;
    o_flags  = '0;
    o_alu_op = alu_pkg::NONE;
    o_len    = '0;
    o_error  = 1'b0;

    case (i_nibble)
      4'h0: begin
        o_route = decoder_pkg::BLOCK_0X;
      end
      4'h2: begin
        o_route = decoder_pkg::BLOCK_2X;
      end
      4'h3: begin
        o_route = decoder_pkg::BLOCK_3X_LEN;
      end
      // 4xy GOC, 5xy GONC
      4'h4, 4'h5: begin
        o_route            = decoder_pkg::COLLECT;
        o_len              = decoder_pkg::JMP_REL2_LEN;
        o_alu_op           = alu_pkg::JMP_REL2;
        o_flags.no_stall   = 1'b1;
        o_flags.test_carry = 1'b1;
        o_flags.carry_val  = !i_nibble[0];
      end
      // 6xxx GOTO, 7xxx GOSUB
      4'h6, 4'h7: begin
        o_route      = decoder_pkg::COLLECT;
        o_len        = decoder_pkg::JMP_REL3_LEN;
        o_alu_op     = alu_pkg::JMP_REL3;
        // gosub pushes the return address
        o_flags.push = i_nibble[0];
      end
      default: begin
        o_error = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/operand_collector.sv ====
// gathers the immediate and jump offset nibbles of an instruction
// a start pulse sets the expected length, each collect pulse stores one
// nibble, lowest position first
`timescale 1ns/10ps
`default_nettype none

module operand_collector (
  input  logic                              i_clk,
  input  logic                              i_reset,
  input  logic                              i_start,
  input  decoder_pkg::operand_len_t         i_len,
  input  logic                              i_collect,
  input  logic [decoder_pkg::NIBBLE_W-1:0]  i_nibble,
  output logic                              o_last,
  output decoder_pkg::operand_t             o_operand,
  output decoder_pkg::operand_len_t         o_operand_len
);

  decoder_pkg::operand_len_t target_len;
  decoder_pkg::operand_len_t count;

  // the nibble being collected now completes the operand
  assign o_last        = (count + 5'd1) == target_len;
  assign o_operand_len = count;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      target_len <= '0;
      count      <= '0;
    end else if (i_start) begin
      target_len <= i_len;
      count      <= '0;
    end else if (i_collect) begin
      count <= count + 5'd1;
    end
  end

  // count stays below 16 while collecting, so its low bits are the slot
  always_ff @(posedge i_clk) begin
    if (i_start) begin
      o_operand <= '0;
    end else if (i_collect) begin
      o_operand[count[3:0]*decoder_pkg::NIBBLE_W +: decoder_pkg::NIBBLE_W] <= i_nibble;
    end
  end

  no_overrun_a: assert property (@(posedge i_clk) disable iff (i_reset)
    i_collect |-> (count < target_len));

endmodule

`default_nettype wire

// ==== source/saturn_decoder.sv ====
// nibble-serial instruction decoder for a Saturn-style 4-bit core
// takes one nibble per valid strobe and reports each instruction record,
// its start address and operand one cycle after its last nibble
`timescale 1ns/10ps
`default_nettype none

module saturn_decoder #(
  parameter int ADDR_W = 20
) (
  input  logic                              i_clk,
  input  logic                              i_reset,
  input  logic                              i_nibble_valid,
  input  logic [decoder_pkg::NIBBLE_W-1:0]  i_nibble,
  input  logic [ADDR_W-1:0]                 i_pc,
  output logic                              o_ins_decoded,
  output logic                              o_dec_error,
  output decoder_pkg::decoded_ins_t         o_ins,
  output logic [ADDR_W-1:0]                 o_ins_addr,
  output decoder_pkg::operand_t             o_operand,
  output decoder_pkg::operand_len_t         o_operand_len
);

  // first nibble decode results
  decoder_pkg::decode_state_t route;
  decoder_pkg::ins_flags_t    first_flags;
  alu_pkg::alu_op_t           first_alu_op;
  decoder_pkg::operand_len_t  first_len;
  logic                       first_error;

  // 0x group results
  decoder_pkg::ins_flags_t    flags_0x;
  alu_pkg::alu_op_t           alu_op_0x;
  logic                       error_0x;

  // collector handshake
  logic                       collect_start;
  decoder_pkg::operand_len_t  collect_len;
  logic                       collect;
  logic                       collect_last;

  first_nibble_decode first_nibble_decode_i (
    .i_nibble (i_nibble),
    .o_route  (route),
    .o_flags  (first_flags),
    .o_alu_op (first_alu_op),
    .o_len    (first_len),
    .o_error  (first_error)
  );

  block_0x_decode block_0x_decode_i (
    .i_nibble (i_nibble),
    .o_flags  (flags_0x),
    .o_alu_op (alu_op_0x),
    .o_error  (error_0x)
  );

  decoder_fsm #(
    .ADDR_W (ADDR_W)
  ) decoder_fsm_i (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_nibble_valid  (i_nibble_valid),
    .i_nibble        (i_nibble),
    .i_pc            (i_pc),
    .i_route         (route),
    .i_first_flags   (first_flags),
    .i_first_alu_op  (first_alu_op),
    .i_first_len     (first_len),
    .i_first_error   (first_error),
    .i_0x_flags      (flags_0x),
    .i_0x_alu_op     (alu_op_0x),
    .i_0x_error      (error_0x),
    .i_collect_last  (collect_last),
    .o_collect_start (collect_start),
    .o_collect_len   (collect_len),
    .o_collect       (collect),
    .o_ins_decoded   (o_ins_decoded),
    .o_dec_error     (o_dec_error),
    .o_ins           (o_ins),
    .o_ins_addr      (o_ins_addr)
  );

  operand_collector operand_collector_i (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_start       (collect_start),
    .i_len         (collect_len),
    .i_collect     (collect),
    .i_nibble      (i_nibble),
    .o_last        (collect_last),
    .o_operand     (o_operand),
    .o_operand_len (o_operand_len)
  );

endmodule

`default_nettype wire

// ==== include/tb_decoder_checks.svh ====
// compare tasks for the instruction decoder testbench
// included inside the testbench module, which declares ADDR_W and error_count
`ifndef TB_DECODER_CHECKS_SVH
`define TB_DECODER_CHECKS_SVH

task automatic check_ins(input decoder_pkg::decoded_ins_t expected,
                         input decoder_pkg::decoded_ins_t actual);
  if (actual !== expected) begin
    $display("MISMATCH o_ins: expected %h, got %h", expected, actual);
    error_count++;
  end
endtask

task automatic check_operand(input decoder_pkg::operand_t expected_op,
                             input decoder_pkg::operand_len_t expected_len,
                             input decoder_pkg::operand_t actual_op,
                             input decoder_pkg::operand_len_t actual_len);
  if (actual_op !== expected_op) begin
    $display("MISMATCH o_operand: expected %h, got %h", expected_op, actual_op);
    error_count++;
  end
  if (actual_len !== expected_len) begin
    $display("MISMATCH o_operand_len: expected %h, got %h", expected_len, actual_len);
    error_count++;
  end
endtask

task automatic check_addr(input logic [ADDR_W-1:0] expected, input logic [ADDR_W-1:0] actual);
  if (actual !== expected) begin
    $display("MISMATCH o_ins_addr: expected %h, got %h", expected, actual);
    error_count++;
  end
endtask

// both strobes, as seen together in one cycle
task automatic check_error(input logic expected_err, input logic expected_dec,
                           input logic actual_err, input logic actual_dec);
  if (actual_err !== expected_err) begin
    $display("MISMATCH o_dec_error: expected %h, got %h", expected_err, actual_err);
    error_count++;
  end
  if (actual_dec !== expected_dec) begin
    $display("MISMATCH o_ins_decoded: expected %h, got %h", expected_dec, actual_dec);
    error_count++;
  end
endtask

`endif

// ==== test/tb_saturn_decoder.sv ====
// directed testbench for the nibble-serial instruction decoder
// feeds whole instructions with random idle gaps and checks each record
`timescale 1ns/10ps
`default_nettype none

module tb_saturn_decoder;

  localparam int ADDR_W         = 20;
  localparam int TIMEOUT_CYCLES = 50;

  logic                              i_clk;
  logic                              i_reset;
  logic                              i_nibble_valid;
  logic [decoder_pkg::NIBBLE_W-1:0]  i_nibble;
  logic [ADDR_W-1:0]                 i_pc;
  logic                              o_ins_decoded;
  logic                              o_dec_error;
  decoder_pkg::decoded_ins_t         o_ins;
  logic [ADDR_W-1:0]                 o_ins_addr;
  decoder_pkg::operand_t             o_operand;
  decoder_pkg::operand_len_t         o_operand_len;

  int                                error_count;
  int                                errors_at_start;
  int                                tests_run;
  int                                tests_failed;
  logic [31:0]                       rng_state;
  logic [ADDR_W-1:0]                 next_pc;
  logic [ADDR_W-1:0]                 start_pc;
  logic [3:0]                        stream [0:17];
  logic                              got_decoded;
  logic                              got_error;

  `include "tb_decoder_checks.svh"

  saturn_decoder #(
    .ADDR_W (ADDR_W)
  ) dut_i (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_nibble_valid (i_nibble_valid),
    .i_nibble       (i_nibble),
    .i_pc           (i_pc),
    .o_ins_decoded  (o_ins_decoded),
    .o_dec_error    (o_dec_error),
    .o_ins          (o_ins),
    .o_ins_addr     (o_ins_addr),
    .o_operand      (o_operand),
    .o_operand_len  (o_operand_len)
  );

  always #5 i_clk = ~i_clk;

  // xorshift32
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // sends stream[0..count-1] while both strobes stay low
  task automatic issue(input int count);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      r = next_random();
      repeat (r[1:0]) begin
        check_error(1'b0, 1'b0, o_dec_error, o_ins_decoded);
        @(negedge i_clk);
      end
      check_error(1'b0, 1'b0, o_dec_error, o_ins_decoded);
      if (i == 0) begin
        start_pc = next_pc;
      end
      i_nibble_valid = 1'b1;
      i_nibble       = stream[i];
      i_pc           = next_pc;
      next_pc        = next_pc + 1'b1;
      @(negedge i_clk);
      i_nibble_valid = 1'b0;
    end
  endtask

  task automatic wait_result();
    int cycles;
    cycles = 0;
    while (!o_ins_decoded && !o_dec_error && cycles < TIMEOUT_CYCLES) begin
      @(negedge i_clk);
      cycles++;
    end
    got_decoded = o_ins_decoded;
    got_error   = o_dec_error;
    if (!got_decoded && !got_error) begin
      $display("timeout, neither strobe rose within %0d cycles", TIMEOUT_CYCLES);
      error_count++;
    end else if (cycles != 0) begin
      $display("strobe rose %0d cycles later than one cycle after the last nibble", cycles);
      error_count++;
    end
    // let the strobe drop before the next instruction
    @(negedge i_clk);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (error_count == errors_at_start) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d mismatches", name, error_count - errors_at_start);
    end
  endtask

  // expected record of the 0x group by instruction meaning
  function automatic decoder_pkg::decoded_ins_t block_0x_record(input logic [3:0] n);
    decoder_pkg::decoded_ins_t e;
    e = '0;
    case (n)
      4'h0, 4'h1, 4'h2, 4'h3, 4'hF: begin
        e.flags.rtn = 1'b1;
        e.flags.pop = 1'b1;
      end
      4'h4, 4'h5: e.flags.set_mode = 1'b1;
      4'h6, 4'h7, 4'h9, 4'hA: e.alu_op = alu_pkg::COPY;
      4'h8: e.alu_op = alu_pkg::ZERO;
      4'hB: e.alu_op = alu_pkg::EXCH;
      4'hC: e.alu_op = alu_pkg::INC;
      4'hD: e.alu_op = alu_pkg::DEC;
      default: e.alu_op = alu_pkg::NONE;
    endcase
    // RTNSXM, RTNSC and RTNCC, RTI, SETDEC, RSTK=C and C=RSTK
    e.flags.set_xm    = (n == 4'h0);
    e.flags.set_carry = (n == 4'h2) || (n == 4'h3);
    e.flags.carry_val = (n == 4'h2);
    e.flags.en_intr   = (n == 4'hF);
    e.flags.mode_dec  = (n == 4'h5);
    e.flags.push      = (n == 4'h6);
    e.flags.pop       = e.flags.pop || (n == 4'h7);
    e.flags.alu_valid = (n >= 4'h6) && (n <= 4'hD);
    return e;
  endfunction

  function automatic decoder_pkg::decoded_ins_t p_load_record(input logic [3:0] n);
    decoder_pkg::decoded_ins_t e;
    e = '0;
    e.flags.alu_valid = 1'b1;
    e.alu_op          = alu_pkg::COPY;
    e.imm_value       = n;
    return e;
  endfunction

  task automatic reset_then_rtn();
    errors_at_start = error_count;
    for (int i = 0; i < 10; i++) begin
      check_error(1'b0, 1'b0, o_dec_error, o_ins_decoded);
      @(negedge i_clk);
    end
    stream[0] = 4'h0;
    stream[1] = 4'h1;
    issue(2);
    wait_result();
    check_error(1'b0, 1'b1, got_error, got_decoded);
    check_ins(block_0x_record(4'h1), o_ins);
    check_addr(start_pc, o_ins_addr);
    finish_test("reset and rtn");
  endtask

  task automatic block_0x_group();
    errors_at_start = error_count;
    for (int n = 0; n < 16; n++) begin
      stream[0] = 4'h0;
      stream[1] = 4'(n);
      issue(2);
      wait_result();
      if (n == 14) begin
        check_error(1'b1, 1'b0, got_error, got_decoded);
      end else begin
        check_error(1'b0, 1'b1, got_error, got_decoded);
        check_ins(block_0x_record(4'(n)), o_ins);
        check_addr(start_pc, o_ins_addr);
        check_operand('0, 5'd0, o_operand, o_operand_len);
      end
    end
    finish_test("0x group");
  endtask

  task automatic p_equals_n();
    errors_at_start = error_count;
    for (int n = 0; n < 16; n++) begin
      stream[0] = 4'h2;
      stream[1] = 4'(n);
      issue(2);
      wait_result();
      check_error(1'b0, 1'b1, got_error, got_decoded);
      check_ins(p_load_record(4'(n)), o_ins);
      check_addr(start_pc, o_ins_addr);
    end
    finish_test("p=n");
  endtask

  task automatic load_constants();
    logic [31:0]               r;
    decoder_pkg::operand_t     exp_op;
    decoder_pkg::decoded_ins_t e;
    errors_at_start = error_count;
    for (int n = 0; n < 16; n++) begin
      exp_op    = '0;
      stream[0] = 4'h3;
      stream[1] = 4'(n);
      for (int k = 0; k <= n; k++) begin
        r = next_random();
        stream[k+2]       = r[3:0];
        exp_op[k*4 +: 4]  = r[3:0];
      end
      e                 = '0;
      e.flags.alu_valid = 1'b1;
      e.flags.no_stall  = 1'b1;
      e.alu_op          = alu_pkg::COPY;
      e.imm_value       = stream[n+2];
      issue(n + 3);
      wait_result();
      check_error(1'b0, 1'b1, got_error, got_decoded);
      check_ins(e, o_ins);
      check_addr(start_pc, o_ins_addr);
      check_operand(exp_op, 5'(n + 1), o_operand, o_operand_len);
    end
    finish_test("load constant");
  endtask

  task automatic relative_jumps();
    logic [31:0]               r;
    int                        len;
    decoder_pkg::operand_t     exp_op;
    decoder_pkg::decoded_ins_t e;
    errors_at_start = error_count;
    for (int op = 4; op < 8; op++) begin
      for (int rep = 0; rep < 3; rep++) begin
        len       = (op < 6) ? 2 : 3;
        exp_op    = '0;
        stream[0] = 4'(op);
        for (int k = 0; k < len; k++) begin
          r = next_random();
          stream[k+1]      = r[3:0];
          exp_op[k*4 +: 4] = r[3:0];
        end
        // operand instructions leave the collector with alu_valid set
        e                  = '0;
        e.flags.alu_valid  = 1'b1;
        e.flags.test_carry = (op < 6);
        e.flags.no_stall   = (op < 6);
        e.flags.carry_val  = (op == 4);
        e.flags.push       = (op == 7);
        e.imm_value        = stream[len];
        if (op < 6) begin
          e.alu_op = alu_pkg::JMP_REL2;
        end else begin
          e.alu_op = alu_pkg::JMP_REL3;
        end
        issue(len + 1);
        wait_result();
        check_error(1'b0, 1'b1, got_error, got_decoded);
        check_ins(e, o_ins);
        check_addr(start_pc, o_ins_addr);
        check_operand(exp_op, 5'(len), o_operand, o_operand_len);
      end
    end
    finish_test("jumps");
  endtask

  task automatic error_recovery();
    errors_at_start = error_count;
    for (int n = 0; n < 16; n++) begin
      if (n == 0 || (n >= 2 && n <= 7)) begin
        continue;
      end
      stream[0] = 4'(n);
      issue(1);
      wait_result();
      check_error(1'b1, 1'b0, got_error, got_decoded);
      stream[0] = 4'h2;
      stream[1] = 4'(n);
      issue(2);
      wait_result();
      check_error(1'b0, 1'b1, got_error, got_decoded);
      check_ins(p_load_record(4'(n)), o_ins);
      check_addr(start_pc, o_ins_addr);
    end
    finish_test("error recovery");
  endtask

  initial begin
    i_clk           = 1'b0;
    i_reset         = 1'b1;
    i_nibble_valid  = 1'b0;
    i_nibble        = '0;
    i_pc            = '0;
    error_count     = 0;
    errors_at_start = 0;
    tests_run       = 0;
    tests_failed    = 0;
    rng_state       = 32'd95381;
    next_pc         = 20'h0_1000;
    start_pc        = '0;
    repeat (8) @(negedge i_clk);
    i_reset = 1'b0;

    reset_then_rtn();
    block_0x_group();
    p_equals_n();
    load_constants();
    relative_jumps();
    error_recovery();

    $display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
